//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_ecc_point_mul
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SIM  := $(BUILD_DIR)/V$(TOP)
SRCS := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search $(LOG) for a pass"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(SIM): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ecc_ctrl_pkg.sv
package ecc_ctrl_pkg;

    localparam int KEY_W = 32;

    // microcode lengths of the two point operations
    localparam int DBL_STEPS = 12;
    localparam int ADD_STEPS = 9;

    typedef logic [KEY_W-1:0] key_t;
    typedef logic [5:0]       key_len_t;   // 1 to 32
    typedef logic [4:0]       bit_idx_t;
    typedef logic [3:0]       step_t;

    // operand sources for field requests
    typedef enum logic [2:0]
    {
        OP_X1,
        OP_Y1,
        OP_BX,
        OP_BY,
        OP_CA,
        OP_T1,
        OP_T2,
        OP_X3
    } operand_sel_t;

    // commit writes y1 and moves x3 into x1
    typedef enum logic [1:0]
    {
        DST_T1,
        DST_T2,
        DST_X3,
        DST_COMMIT
    } dest_sel_t;

    typedef enum logic [1:0]
    {
        LOOP_IDLE,
        LOOP_DOUBLE,
        LOOP_ADD,
        LOOP_FINISH
    } loop_state_t;

    typedef enum logic [1:0]
    {
        SEQ_IDLE,
        SEQ_REQ,
        SEQ_GAP
    } seq_state_t;

endpackage

//--- ecc_field_pkg.sv
package ecc_field_pkg;

    // prime field element
    localparam int FIELD_W = 32;

    typedef logic [FIELD_W-1:0] field_t;

    // field unit opcodes
    typedef enum logic [1:0]
    {
        GF_ADD = 2'd0,
        GF_SUB = 2'd1,
        GF_MUL = 2'd2,
        GF_DIV = 2'd3
    } gf_op_t;

endpackage

//--- ecc_point_mul_top.sv
`timescale 1ns/1ps

module ecc_point_mul_top
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_load,
    input  ecc_ctrl_pkg::key_t     i_key,
    input  ecc_ctrl_pkg::key_len_t i_key_len,
    input  ecc_field_pkg::field_t  i_curve_a,
    input  ecc_field_pkg::field_t  i_px,
    input  ecc_field_pkg::field_t  i_py,
    input  logic                   i_start,
    output logic                   o_busy,
    output logic                   o_done,
    output ecc_field_pkg::field_t  o_x,
    output ecc_field_pkg::field_t  o_y,
    output logic                   o_gf_req,
    output ecc_field_pkg::gf_op_t  o_gf_op,
    output ecc_field_pkg::field_t  o_gf_a,
    output ecc_field_pkg::field_t  o_gf_b,
    input  logic                   i_gf_done,
    input  ecc_field_pkg::field_t  i_gf_result
);

    ecc_ctrl_pkg::bit_idx_t bit_idx;
    ecc_ctrl_pkg::key_len_t key_len;
    ecc_field_pkg::field_t  curve_a;
    ecc_field_pkg::field_t  bx;
    ecc_field_pkg::field_t  by;

    logic key_bit;
    logic op_start;
    logic op_is_add;
    logic op_done;
    logic init;

    field_op_if f_op_if ();

    key_config_regs key_config_regs_inst
    (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_load    (i_load),
        .i_busy    (o_busy),
        .i_key     (i_key),
        .i_key_len (i_key_len),
        .i_curve_a (i_curve_a),
        .i_px      (i_px),
        .i_py      (i_py),
        .i_bit_idx (bit_idx),
        .o_key_bit (key_bit),
        .o_key_len (key_len),
        .o_curve_a (curve_a),
        .o_bx      (bx),
        .o_by      (by)
    );

    scalar_loop_ctrl scalar_loop_ctrl_inst
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_key_bit   (key_bit),
        .i_op_done   (op_done),
        .i_key_len   (key_len),
        .o_bit_idx   (bit_idx),
        .o_op_start  (op_start),
        .o_op_is_add (op_is_add),
        .o_init      (init),
        .o_busy      (o_busy),
        .o_done      (o_done)
    );

    point_op_seq point_op_seq_inst
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_op_start  (op_start),
        .i_op_is_add (op_is_add),
        .i_init      (init),
        .i_gf_done   (i_gf_done),
        .f_op        (f_op_if.seq),
        .o_gf_req    (o_gf_req),
        .o_gf_op     (o_gf_op),
        .o_op_done   (op_done)
    );

    point_reg_file point_reg_file_inst
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_gf_result (i_gf_result),
        .i_bx        (bx),
        .i_by        (by),
        .i_curve_a   (curve_a),
        .f_op        (f_op_if.regs),
        .o_x         (o_x),
        .o_y         (o_y)
    );

    assign o_gf_a = f_op_if.opnd_a;
    assign o_gf_b = f_op_if.opnd_b;

endmodule

//--- field_op_if.sv
`timescale 1ns/1ps

interface field_op_if;

    ecc_ctrl_pkg::operand_sel_t src_a;
    ecc_ctrl_pkg::operand_sel_t src_b;
    ecc_ctrl_pkg::dest_sel_t    dst;
    logic                       wr;      // result write strobe
    logic                       init;    // load accumulator from base point
    ecc_field_pkg::field_t      opnd_a;
    ecc_field_pkg::field_t      opnd_b;

    modport seq
    (
        output src_a, src_b, dst, wr, init,
        input  opnd_a, opnd_b
    );

    modport regs
    (
        input  src_a, src_b, dst, wr, init,
        output opnd_a, opnd_b
    );

endinterface

//--- key_config_regs.sv
`timescale 1ns/1ps

module key_config_regs
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_load,
    input  logic                   i_busy,
    input  ecc_ctrl_pkg::key_t     i_key,
    input  ecc_ctrl_pkg::key_len_t i_key_len,
    input  ecc_field_pkg::field_t  i_curve_a,
    input  ecc_field_pkg::field_t  i_px,
    input  ecc_field_pkg::field_t  i_py,
    input  ecc_ctrl_pkg::bit_idx_t i_bit_idx,
    output logic                   o_key_bit,
    output ecc_ctrl_pkg::key_len_t o_key_len,
    output ecc_field_pkg::field_t  o_curve_a,
    output ecc_field_pkg::field_t  o_bx,
    output ecc_field_pkg::field_t  o_by
);

    ecc_ctrl_pkg::key_t key_r;

    logic load_ok;

    assign load_ok = i_load && !i_busy;   // no config change mid-run

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            key_r     <= '0;
            o_key_len <= 6'd1;
        end
        else if (load_ok)
        begin
            key_r     <= i_key;
            o_key_len <= i_key_len;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (load_ok)
        begin
            o_curve_a <= i_curve_a;
            o_bx      <= i_px;
            o_by      <= i_py;
        end
    end

    assign o_key_bit = key_r[i_bit_idx];

endmodule

//--- point_op_seq.sv
`timescale 1ns/1ps

module point_op_seq
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  logic                  i_op_start,
    input  logic                  i_op_is_add,
    input  logic                  i_init,
    input  logic                  i_gf_done,
    field_op_if.seq               f_op,
    output logic                  o_gf_req,
    output ecc_field_pkg::gf_op_t o_gf_op,
    output logic                  o_op_done
);

    ecc_ctrl_pkg::seq_state_t state;
    ecc_ctrl_pkg::step_t      step;

    logic       is_add;
    logic       last_step;
    logic [9:0] uword;   // {op, src_a, src_b, dst}

    function automatic logic [9:0] uop
    (
        input ecc_field_pkg::gf_op_t       op,
        input ecc_ctrl_pkg::operand_sel_t  a,
        input ecc_ctrl_pkg::operand_sel_t  b,
        input ecc_ctrl_pkg::dest_sel_t     d
    );
        return {op, a, b, d};
    endfunction

    always_comb
    begin
        uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_T2,
                    ecc_ctrl_pkg::OP_Y1, ecc_ctrl_pkg::DST_COMMIT);
        if (!is_add)
        begin
            case (step)   // point double
                4'd0:  uword = uop(ecc_field_pkg::GF_MUL, ecc_ctrl_pkg::OP_X1,
                                   ecc_ctrl_pkg::OP_X1, ecc_ctrl_pkg::DST_T1);
                4'd1:  uword = uop(ecc_field_pkg::GF_ADD, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T1, ecc_ctrl_pkg::DST_T2);
                4'd2:  uword = uop(ecc_field_pkg::GF_ADD, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_T1, ecc_ctrl_pkg::DST_T1);
                4'd3:  uword = uop(ecc_field_pkg::GF_ADD, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_CA, ecc_ctrl_pkg::DST_T1);
                4'd4:  uword = uop(ecc_field_pkg::GF_ADD, ecc_ctrl_pkg::OP_Y1,
                                   ecc_ctrl_pkg::OP_Y1, ecc_ctrl_pkg::DST_T2);
                4'd5:  uword = uop(ecc_field_pkg::GF_DIV, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T2, ecc_ctrl_pkg::DST_T1);
                4'd6:  uword = uop(ecc_field_pkg::GF_MUL, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T1, ecc_ctrl_pkg::DST_T2);
                4'd7:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_X1, ecc_ctrl_pkg::DST_T2);
                4'd8:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_X1, ecc_ctrl_pkg::DST_X3);
                4'd9:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_X1,
                                   ecc_ctrl_pkg::OP_X3, ecc_ctrl_pkg::DST_T2);
                4'd10: uword = uop(ecc_field_pkg::GF_MUL, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T2, ecc_ctrl_pkg::DST_T2);
                default: ;   // step 11 is the commit
            endcase
        end
        else
        begin
            case (step)   // point add of the base point
                4'd0:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_BX,
                                   ecc_ctrl_pkg::OP_X1, ecc_ctrl_pkg::DST_T1);
                4'd1:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_BY,
                                   ecc_ctrl_pkg::OP_Y1, ecc_ctrl_pkg::DST_T2);
                4'd2:  uword = uop(ecc_field_pkg::GF_DIV, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_T1, ecc_ctrl_pkg::DST_T1);
                4'd3:  uword = uop(ecc_field_pkg::GF_MUL, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T1, ecc_ctrl_pkg::DST_T2);
                4'd4:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_X1, ecc_ctrl_pkg::DST_T2);
                4'd5:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_T2,
                                   ecc_ctrl_pkg::OP_BX, ecc_ctrl_pkg::DST_X3);
                4'd6:  uword = uop(ecc_field_pkg::GF_SUB, ecc_ctrl_pkg::OP_X1,
                                   ecc_ctrl_pkg::OP_X3, ecc_ctrl_pkg::DST_T2);
                4'd7:  uword = uop(ecc_field_pkg::GF_MUL, ecc_ctrl_pkg::OP_T1,
                                   ecc_ctrl_pkg::OP_T2, ecc_ctrl_pkg::DST_T2);
                default: ;   // step 8 is the commit
            endcase
        end
    end

    assign o_gf_op    = ecc_field_pkg::gf_op_t'(uword[9:8]);
    assign f_op.src_a = ecc_ctrl_pkg::operand_sel_t'(uword[7:5]);
    assign f_op.src_b = ecc_ctrl_pkg::operand_sel_t'(uword[4:2]);
    assign f_op.dst   = ecc_ctrl_pkg::dest_sel_t'(uword[1:0]);
    assign f_op.init  = i_init;

    assign last_step = is_add ? (step == ecc_ctrl_pkg::step_t'(ecc_ctrl_pkg::ADD_STEPS - 1))
                              : (step == ecc_ctrl_pkg::step_t'(ecc_ctrl_pkg::DBL_STEPS - 1));

    assign o_gf_req  = (state == ecc_ctrl_pkg::SEQ_REQ);
    assign f_op.wr   = o_gf_req && i_gf_done;   // result lands on the done edge
    assign o_op_done = f_op.wr && last_step;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state  <= ecc_ctrl_pkg::SEQ_IDLE;
            step   <= '0;
            is_add <= 1'b0;
        end
        else
        begin
            case (state)
                ecc_ctrl_pkg::SEQ_IDLE:
                begin
                    if (i_op_start)
                    begin
                        is_add <= i_op_is_add;
                        step   <= '0;
                        state  <= ecc_ctrl_pkg::SEQ_REQ;
                    end
                end
                ecc_ctrl_pkg::SEQ_REQ:
                begin
                    if (i_gf_done)
                    begin
                        if (last_step)
                        begin
                            state <= ecc_ctrl_pkg::SEQ_IDLE;
                        end
                        else
                        begin
                            step  <= step + 1'b1;
                            state <= ecc_ctrl_pkg::SEQ_GAP;
                        end
                    end
                end
                default:
                begin
                    state <= ecc_ctrl_pkg::SEQ_REQ;   // one low cycle between requests
                end
            endcase
        end
    end

endmodule

//--- point_reg_file.sv
`timescale 1ns/1ps

module point_reg_file
(
    input  logic                  i_clk,
    input  logic                  i_reset,
    input  ecc_field_pkg::field_t i_gf_result,
    input  ecc_field_pkg::field_t i_bx,
    input  ecc_field_pkg::field_t i_by,
    input  ecc_field_pkg::field_t i_curve_a,
    field_op_if.regs              f_op,
    output ecc_field_pkg::field_t o_x,
    output ecc_field_pkg::field_t o_y
);

    ecc_field_pkg::field_t x1;   // accumulator
    ecc_field_pkg::field_t y1;
    ecc_field_pkg::field_t t1;
    ecc_field_pkg::field_t t2;
    ecc_field_pkg::field_t x3;

    function automatic ecc_field_pkg::field_t pick(input ecc_ctrl_pkg::operand_sel_t sel);
        case (sel)
            ecc_ctrl_pkg::OP_X1: return x1;
            ecc_ctrl_pkg::OP_Y1: return y1;
            ecc_ctrl_pkg::OP_BX: return i_bx;
            ecc_ctrl_pkg::OP_BY: return i_by;
            ecc_ctrl_pkg::OP_CA: return i_curve_a;
            ecc_ctrl_pkg::OP_T1: return t1;
            ecc_ctrl_pkg::OP_T2: return t2;
            default:             return x3;
        endcase
    endfunction

    assign f_op.opnd_a = pick(f_op.src_a);
    assign f_op.opnd_b = pick(f_op.src_b);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            x1 <= '0;
            y1 <= '0;
        end
        else if (f_op.init)
        begin
            x1 <= i_bx;   // start from the base point
            y1 <= i_by;
        end
        else if (f_op.wr && f_op.dst == ecc_ctrl_pkg::DST_COMMIT)
        begin
            x1 <= x3;
            y1 <= i_gf_result;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (f_op.wr)
        begin
            case (f_op.dst)
                ecc_ctrl_pkg::DST_T1: t1 <= i_gf_result;
                ecc_ctrl_pkg::DST_T2: t2 <= i_gf_result;
                ecc_ctrl_pkg::DST_X3: x3 <= i_gf_result;
                default: ;   // commit handled with the accumulator
            endcase
        end
    end

    assign o_x = x1;
    assign o_y = y1;

endmodule

//--- scalar_loop_ctrl.sv
`timescale 1ns/1ps

module scalar_loop_ctrl
(
    input  logic                   i_clk,
    input  logic                   i_reset,
    input  logic                   i_start,
    input  logic                   i_key_bit,
    input  logic                   i_op_done,
    input  ecc_ctrl_pkg::key_len_t i_key_len,
    output ecc_ctrl_pkg::bit_idx_t o_bit_idx,
    output logic                   o_op_start,
    output logic                   o_op_is_add,
    output logic                   o_init,
    output logic                   o_busy,
    output logic                   o_done
);

    ecc_ctrl_pkg::loop_state_t state;

    logic last_bit;

    assign last_bit = (o_bit_idx == '0);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state       <= ecc_ctrl_pkg::LOOP_IDLE;
            o_bit_idx   <= '0;
            o_op_start  <= 1'b0;
            o_op_is_add <= 1'b0;
            o_init      <= 1'b0;
            o_busy      <= 1'b0;
            o_done      <= 1'b0;
        end
        else
        begin
            o_op_start <= 1'b0;   // pulses by default
            o_init     <= 1'b0;
            o_done     <= 1'b0;
            case (state)
                ecc_ctrl_pkg::LOOP_IDLE:
                begin
                    if (i_start)
                    begin
                        o_init <= 1'b1;
                        o_busy <= 1'b1;
                        if (i_key_len <= 6'd1)
                        begin
                            state <= ecc_ctrl_pkg::LOOP_FINISH;   // only the implied top bit
                        end
                        else
                        begin
                            o_bit_idx   <= ecc_ctrl_pkg::bit_idx_t'(i_key_len - 6'd2);
                            o_op_start  <= 1'b1;
                            o_op_is_add <= 1'b0;
                            state       <= ecc_ctrl_pkg::LOOP_DOUBLE;
                        end
                    end
                end
                ecc_ctrl_pkg::LOOP_DOUBLE:
                begin
                    if (i_op_done)
                    begin
                        if (i_key_bit)
                        begin
                            o_op_start  <= 1'b1;
                            o_op_is_add <= 1'b1;
                            state       <= ecc_ctrl_pkg::LOOP_ADD;
                        end
                        else if (last_bit)
                        begin
                            state <= ecc_ctrl_pkg::LOOP_FINISH;
                        end
                        else
                        begin
                            o_bit_idx   <= o_bit_idx - 1'b1;
                            o_op_start  <= 1'b1;
                            o_op_is_add <= 1'b0;
                        end
                    end
                end
                ecc_ctrl_pkg::LOOP_ADD:
                begin
                    if (i_op_done)
                    begin
                        if (last_bit)
                        begin
                            state <= ecc_ctrl_pkg::LOOP_FINISH;
                        end
                        else
                        begin
                            o_bit_idx   <= o_bit_idx - 1'b1;
                            o_op_start  <= 1'b1;
                            o_op_is_add <= 1'b0;
                            state       <= ecc_ctrl_pkg::LOOP_DOUBLE;
                        end
                    end
                end
                default:
                begin
                    o_done <= 1'b1;   // busy drops with done
                    o_busy <= 1'b0;
                    state  <= ecc_ctrl_pkg::LOOP_IDLE;
                end
            endcase
        end
    end

endmodule

//--- tb_ecc_point_mul.sv
`timescale 1ns/1ps

module tb_ecc_point_mul;

    localparam logic [31:0] PRIME   = 32'hfffffffb;
    localparam logic [31:0] SEED    = 32'hfea0;
    localparam int          TIMEOUT = 20000;   // cycles per run
    localparam int          DBL_REQS = 12;
    localparam int          ADD_REQS = 9;

    logic                   i_clk;
    logic                   i_reset;
    logic                   i_load;
    ecc_ctrl_pkg::key_t     i_key;
    ecc_ctrl_pkg::key_len_t i_key_len;
    ecc_field_pkg::field_t  i_curve_a;
    ecc_field_pkg::field_t  i_px;
    ecc_field_pkg::field_t  i_py;
    logic                   i_start;
    logic                   o_busy;
    logic                   o_done;
    ecc_field_pkg::field_t  o_x;
    ecc_field_pkg::field_t  o_y;
    logic                   o_gf_req;
    ecc_field_pkg::gf_op_t  o_gf_op;
    ecc_field_pkg::field_t  o_gf_a;
    ecc_field_pkg::field_t  o_gf_b;
    logic                   i_gf_done;
    ecc_field_pkg::field_t  i_gf_result;

    int errors = 0;
    int checks = 0;
    int req_count = 0;
    bit aborted = 0;

    logic                  req_q = 1'b0;
    logic                  done_q = 1'b0;
    logic [1:0]            op_q;
    ecc_field_pkg::field_t a_q;
    ecc_field_pkg::field_t b_q;

    ecc_point_mul_top ecc_point_mul_top_inst
    (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_load      (i_load),
        .i_key       (i_key),
        .i_key_len   (i_key_len),
        .i_curve_a   (i_curve_a),
        .i_px        (i_px),
        .i_py        (i_py),
        .i_start     (i_start),
        .o_busy      (o_busy),
        .o_done      (o_done),
        .o_x         (o_x),
        .o_y         (o_y),
        .o_gf_req    (o_gf_req),
        .o_gf_op     (o_gf_op),
        .o_gf_a      (o_gf_a),
        .o_gf_b      (o_gf_b),
        .i_gf_done   (i_gf_done),
        .i_gf_result (i_gf_result)
    );

    always #4 i_clk = ~i_clk;

    function automatic logic [31:0] add_mod(input logic [31:0] a, input logic [31:0] b);
        return 32'(({32'd0, a} + {32'd0, b}) % {32'd0, PRIME});
    endfunction

    function automatic logic [31:0] sub_mod(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] nb;
        nb = {32'd0, PRIME} - ({32'd0, b} % {32'd0, PRIME});
        return 32'(({32'd0, a} + nb) % {32'd0, PRIME});
    endfunction

    function automatic logic [31:0] mul_mod(input logic [31:0] a, input logic [31:0] b);
        logic [63:0] prod;
        prod = {32'd0, a} * {32'd0, b};
        return 32'(prod % {32'd0, PRIME});
    endfunction

    function automatic logic [31:0] pow_mod(input logic [31:0] b, input logic [31:0] e);
        logic [31:0] result;
        logic [31:0] base;
        result = 32'd1;
        base   = 32'(({32'd0, b}) % {32'd0, PRIME});
        for (int i = 0; i < 32; i++)
        begin
            if (e[i])
                result = mul_mod(result, base);
            base = mul_mod(base, base);
        end
        return result;
    endfunction

    // Fermat inverse gives zero for a zero divisor
    function automatic logic [31:0] div_mod(input logic [31:0] a, input logic [31:0] b);
        return mul_mod(a, pow_mod(b, PRIME - 32'd2));
    endfunction

    function automatic logic [31:0] apply_op(input logic [1:0] op, input logic [31:0] a,
                                             input logic [31:0] b);
        case (op)
            2'd0:    return add_mod(a, b);
            2'd1:    return sub_mod(a, b);
            2'd2:    return mul_mod(a, b);
            default: return div_mod(a, b);
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic double_point(inout logic [31:0] x, inout logic [31:0] y,
                                input logic [31:0] ca);
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] x3;
        t1 = mul_mod(x, x);
        t2 = add_mod(t1, t1);
        t1 = add_mod(t2, t1);
        t1 = add_mod(t1, ca);
        t2 = add_mod(y, y);
        t1 = div_mod(t1, t2);   // slope (3x^2+a)/2y
        t2 = mul_mod(t1, t1);
        t2 = sub_mod(t2, x);
        x3 = sub_mod(t2, x);
        t2 = sub_mod(x, x3);
        t2 = mul_mod(t1, t2);
        y  = sub_mod(t2, y);
        x  = x3;
    endtask

    task automatic add_point(inout logic [31:0] x, inout logic [31:0] y,
                             input logic [31:0] bx, input logic [31:0] by);
        logic [31:0] t1;
        logic [31:0] t2;
        logic [31:0] x3;
        t1 = sub_mod(bx, x);
        t2 = sub_mod(by, y);
        t1 = div_mod(t2, t1);
        t2 = mul_mod(t1, t1);
        t2 = sub_mod(t2, x);
        x3 = sub_mod(t2, bx);
        t2 = sub_mod(x, x3);
        t2 = mul_mod(t1, t2);
        y  = sub_mod(t2, y);
        x  = x3;
    endtask

    // left to right walk with the top bit implied
    task automatic scalar_mult(input logic [31:0] key, input int len, input logic [31:0] ca,
                               input logic [31:0] px, input logic [31:0] py,
                               output logic [31:0] x, output logic [31:0] y,
                               output int reqs);
        x    = px;
        y    = py;
        reqs = 0;
        for (int i = len - 2; i >= 0; i--)
        begin
            double_point(x, y, ca);
            reqs += DBL_REQS;
            if (key[i])
            begin
                add_point(x, y, px, py);
                reqs += ADD_REQS;
            end
        end
    endtask

    task automatic load_config(input logic [31:0] key, input int len, input logic [31:0] ca,
                               input logic [31:0] px, input logic [31:0] py);
        i_key     = key;
        i_key_len = ecc_ctrl_pkg::key_len_t'(len);
        i_curve_a = ca;
        i_px      = px;
        i_py      = py;
        i_load    = 1'b1;
        @(posedge i_clk);
        #1;
        i_load = 1'b0;
    endtask

    task automatic wait_for_done(input int limit, output bit ok);
        int n;
        n = 0;
        while (!o_done && n < limit)
        begin
            @(posedge i_clk);
            #1;
            n++;
        end
        ok = o_done;
    endtask

    task automatic poke_while_busy();
        repeat (4)
        begin
            @(posedge i_clk);
            #1;
        end
        check_value("o_busy", o_busy, 1);
        i_key     = $urandom;
        i_key_len = ecc_ctrl_pkg::key_len_t'($urandom_range(32, 1));
        i_curve_a = $urandom;
        i_px      = $urandom;
        i_py      = $urandom;
        i_load    = 1'b1;   // both must be ignored mid-run
        i_start   = 1'b1;
        @(posedge i_clk);
        #1;
        i_load  = 1'b0;
        i_start = 1'b0;
    endtask

    task automatic start_and_check(input logic [31:0] ex, input logic [31:0] ey,
                                   input int exp_reqs, input int limit, input bit poke);
        bit ok;
        if (!aborted)
        begin
            req_count = 0;
            i_start   = 1'b1;
            @(posedge i_clk);
            #1;
            i_start = 1'b0;
            check_value("o_busy", o_busy, 1);
            if (poke)
                poke_while_busy();
            wait_for_done(limit, ok);
            if (!ok)
            begin
                $display("timeout: o_done did not arrive within %0d cycles of start", limit);
                errors++;
                aborted = 1;
            end
            else
            begin
                check_value("o_x", o_x, ex);
                check_value("o_y", o_y, ey);
                check_value("o_busy", o_busy, 0);
                check_value("request count", req_count, exp_reqs);
            end
        end
    endtask

    task automatic run_case(input logic [31:0] key, input int len, input logic [31:0] ca,
                            input logic [31:0] px, input logic [31:0] py, input int limit);
        logic [31:0] ex;
        logic [31:0] ey;
        int          exp_reqs;
        scalar_mult(key, len, ca, px, py, ex, ey, exp_reqs);
        load_config(key, len, ca, px, py);
        start_and_check(ex, ey, exp_reqs, limit, 1'b0);
    endtask

    task automatic check_hold(input logic [31:0] ex, input logic [31:0] ey);
        repeat (4)
        begin
            @(posedge i_clk);
            #1;
            if (!aborted)
            begin
                check_value("o_x", o_x, ex);
                check_value("o_y", o_y, ey);
                check_value("o_busy", o_busy, 0);
                check_value("o_done", o_done, 0);   // done is a single cycle pulse
            end
        end
    endtask

    // field unit model with one done pulse per request
    initial
    begin
        logic [1:0]  op;
        logic [31:0] a;
        logic [31:0] b;
        int          lat;
        forever
        begin
            @(posedge i_clk);
            #1;
            if (o_gf_req && !i_reset)
            begin
                op  = o_gf_op;
                a   = o_gf_a;
                b   = o_gf_b;
                lat = $urandom_range(6, 1);
                repeat (lat - 1)
                begin
                    @(posedge i_clk);
                    #1;
                end
                i_gf_result = apply_op(op, a, b);
                i_gf_done   = 1'b1;
                @(posedge i_clk);
                #1;
                i_gf_done = 1'b0;
            end
        end
    end

    always @(negedge i_clk)
    begin
        if (!i_reset)
        begin
            if (o_gf_req && !req_q)
                req_count++;
            if (o_gf_req && req_q && !done_q)
            begin
                check_value("o_gf_op", o_gf_op, op_q);
                check_value("o_gf_a", o_gf_a, a_q);
                check_value("o_gf_b", o_gf_b, b_q);
            end
            if (req_q && done_q)
                check_value("o_gf_req", o_gf_req, 0);   // gap after each request
        end
        req_q  = o_gf_req;
        done_q = i_gf_done;
        op_q   = o_gf_op;
        a_q    = o_gf_a;
        b_q    = o_gf_b;
    end

    initial
    begin
        logic [31:0] ex;
        logic [31:0] ey;
        int          exp_reqs;
        logic [31:0] key;
        int          len;
        logic [31:0] ca;
        logic [31:0] px;
        logic [31:0] py;
        void'($urandom(SEED));
        i_clk       = 1'b0;
        i_reset     = 1'b1;
        i_load      = 1'b0;
        i_key       = '0;
        i_key_len   = 6'd1;
        i_curve_a   = '0;
        i_px        = '0;
        i_py        = '0;
        i_start     = 1'b0;
        i_gf_done   = 1'b0;
        i_gf_result = '0;
        repeat (8) @(posedge i_clk);
        #1;
        i_reset = 1'b0;
        check_value("o_busy", o_busy, 0);
        check_value("o_done", o_done, 0);
        check_value("o_gf_req", o_gf_req, 0);

        ca = $urandom % PRIME;
        px = $urandom % PRIME;
        py = $urandom % PRIME;
        run_case($urandom, 1, ca, px, py, 3);   // base point back with no requests

        for (int n = 0; n < 20; n++)
        begin
            key = $urandom;
            len = $urandom_range(32, 1);
            ca  = $urandom % PRIME;
            px  = $urandom % PRIME;
            py  = $urandom % PRIME;
            run_case(key, len, ca, px, py, TIMEOUT);
        end

        key = $urandom;
        len = $urandom_range(32, 8);
        ca  = $urandom % PRIME;
        px  = $urandom % PRIME;
        py  = $urandom % PRIME;
        scalar_mult(key, len, ca, px, py, ex, ey, exp_reqs);
        load_config(key, len, ca, px, py);
        start_and_check(ex, ey, exp_reqs, TIMEOUT, 1'b1);
        check_hold(ex, ey);
        start_and_check(ex, ey, exp_reqs, TIMEOUT, 1'b0);   // stored config survives

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

//--- vlog.f
ecc_field_pkg.sv
ecc_ctrl_pkg.sv
field_op_if.sv
key_config_regs.sv
scalar_loop_ctrl.sv
point_op_seq.sv
point_reg_file.sv
ecc_point_mul_top.sv
tb_ecc_point_mul.sv
